// ==== src.f ====
+incdir+verification
verilog/game_pkg.sv
verilog/button_debounce.sv
verilog/game_fsm.sv
verilog/player_position.sv
verilog/obstacle_field.sv
verilog/frame_composer.sv
verilog/game_top.sv
verification/game_tb.sv

// ==== verification/game_tests.svh ====
/* Directed tests of the dodging game, included inside the testbench module
   Each task drives the buttons and checks the frame and score against the model */

// Button held low for 8 cycles, then released for 8
task automatic press_button(input int which);
	@(posedge clock_50);
	#1;
	case (which)
		KEY_START: start_button = 1'b0;
		KEY_LEFT:  left_button = 1'b0;
		default:   right_button = 1'b0;
	endcase
	repeat (8) @(posedge clock_50);
	#1;
	start_button = 1'b1;
	left_button  = 1'b1;
	right_button = 1'b1;
	repeat (8) @(posedge clock_50);
endtask

// ==============================
// Idle and game start
// ==============================
task automatic idle_buttons_ignored();
	check_frame();
	check_score('0);
	// Moves have no effect on the start screen
	press_button(KEY_LEFT);
	check_frame();
	press_button(KEY_RIGHT);
	check_frame();
	check_score('0);
endtask

task automatic start_clears_field();
	press_button(KEY_START);
	restart_model(st_play);
	// Empty field, players at their start columns
	check_frame();
	check_score('0);
endtask

// Steps run meanwhile but the field has not reached the players
task automatic players_clamp();
	repeat (4) begin
		press_button(KEY_LEFT);
		model_pos = move_players(model_pos, KEY_LEFT);
		check_row(PLAYER_ROW, player_bits(model_pos));
	end
	check_row(PLAYER_ROW, (row_t'(1) << P1_MIN_COL) | (row_t'(1) << P2_MIN_COL));
	repeat (5) begin
		press_button(KEY_RIGHT);
		model_pos = move_players(model_pos, KEY_RIGHT);
		check_row(PLAYER_ROW, player_bits(model_pos));
	end
	check_row(PLAYER_ROW, (row_t'(1) << P1_MAX_COL) | (row_t'(1) << P2_MAX_COL));
endtask

// ==============================
// Falling field and collision
// ==============================
task automatic field_follows_table();
	int guard;
	score_t prev;
	// Catch up with the steps taken during the moves
	guard = 0;
	while (model_score != score && guard < FIELD_ROWS) begin
		advance_model();
		guard++;
	end
	guard = 0;
	while (!collision_ahead() && guard < 2 * FIELD_ROWS) begin
		guard++;
		prev = model_score;
		wait_for_step();
		advance_model();
		check_score(prev + 8'd1);
		check_frame();
	end
endtask

task automatic collision_ends_game();
	// Next step lands an obstacle on the players
	wait_for_step();
	advance_model();
	check_score(model_score);
	check_frame();
	// Score stays frozen on the result screen
	repeat (2 * STEP_CYCLES) @(posedge clock_50);
	check_score(model_score);
	press_button(KEY_START);
	model_state = st_idle;
	check_frame();
	check_score(model_score);
endtask

// ==============================
// Full game to the win screen
// ==============================
task automatic steered_game_wins();
	int guard;
	int m;
	press_button(KEY_START);
	restart_model(st_play);
	check_frame();
	check_score('0);
	guard = 0;
	while (model_state == st_play && guard < 2 * WIN_SCORE) begin
		guard++;
		wait_for_step();
		advance_model();
		check_score(model_score);
		check_frame();
		if (model_state == st_play) begin
			// Dodge the row that lands next
			m = pick_dodge_move();
			if (m != 0) begin
				press_button(m);
				model_pos = move_players(model_pos, m);
			end
			check_row(PLAYER_ROW, expected_row(PLAYER_ROW));
		end
	end
	// Game must end at the target score
	check_score(WIN_SCORE);
endtask

// ==== verification/game_tb.sv ====
/* Testbench of the dodging game with shortened step and debounce times
   Holds the reference model and check helpers, runs the tests from the included file */
`timescale 1ns/1ps

module game_tb;

	import game_pkg::*;

	// Short timing for simulation
	localparam int STEP_CYCLES     = 32;
	localparam int DEBOUNCE_CYCLES = 4;
	// 40 steps cover both games plus the presses, margin for the rest
	localparam int TIMEOUT_CYCLES  = 40 * STEP_CYCLES + 2000;
	// Button codes, left and right double as move codes, 0 means no move
	localparam int KEY_START = 0;
	localparam int KEY_LEFT  = 1;
	localparam int KEY_RIGHT = 2;

	logic      clock_50;
	logic      rst_n;
	logic      start_button;
	logic      left_button;
	logic      right_button;
	row_addr_t disp_addr;
	row_t      disp_data;
	score_t    score;

	// ==============================
	// Reference model state
	// ==============================
	game_state_t model_state;
	score_t      model_score;
	hit_t        model_alive;
	player_pos_t model_pos;
	row_t        model_field [FIELD_ROWS];
	// Next table entry to enter at the top
	int          model_idx;
	// Survivable positions per remaining step, one bit per position
	logic [15:0] reach_tbl [0:31];

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;

	game_top #(
		.step_cycles     (STEP_CYCLES),
		.debounce_cycles (DEBOUNCE_CYCLES)
	) u_game_top (
		.clock_50     (clock_50),
		.rst_n        (rst_n),
		.start_button (start_button),
		.left_button  (left_button),
		.right_button (right_button),
		.disp_addr    (disp_addr),
		.disp_data    (disp_data),
		.score        (score)
	);

	always #4 clock_50 = ~clock_50;

	// Run limit
	always @(posedge clock_50) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
			$display("Verification failed");
			$finish;
		end
	end

	// ==============================
	// Model helpers
	// ==============================
	function automatic row_t player_bits(player_pos_t p);
		row_t r;
		r = '0;
		r[p.p1_col] = 1'b1;
		r[p.p2_col] = 1'b1;
		return r;
	endfunction

	// Expected frame row for the model's state
	function automatic row_t expected_row(int a);
		row_t r;
		if (model_state == st_idle) begin
			r = SCREEN_START[a];
		end else if (model_state == st_play) begin
			if (a == PLAYER_ROW) begin
				r = player_bits(model_pos);
			end else begin
				r = model_field[a];
			end
		end else if (model_alive.p1 && model_alive.p2) begin
			r = SCREEN_WIN[a];
		end else if (model_alive.p1) begin
			r = SCREEN_P1[a];
		end else if (model_alive.p2) begin
			r = SCREEN_P2[a];
		end else begin
			r = SCREEN_OVER[a];
		end
		return r;
	endfunction

	// Shared move, each column clamped to its own half
	function automatic player_pos_t move_players(player_pos_t p, int m);
		player_pos_t n;
		n = p;
		if (m == KEY_LEFT) begin
			if (p.p1_col > P1_MIN_COL) n.p1_col = p.p1_col - 3'd1;
			if (p.p2_col > P2_MIN_COL) n.p2_col = p.p2_col - 3'd1;
		end else if (m == KEY_RIGHT) begin
			if (p.p1_col < P1_MAX_COL) n.p1_col = p.p1_col + 3'd1;
			if (p.p2_col < P2_MAX_COL) n.p2_col = p.p2_col + 3'd1;
		end
		return n;
	endfunction

	function automatic bit lane_clear(row_t r, player_pos_t p);
		return !r[p.p1_col] && !r[p.p2_col];
	endfunction

	function automatic bit collision_ahead();
		return !lane_clear(model_field[FIELD_ROWS - 1], model_pos);
	endfunction

	// Row that lands on the players at the j-th step from now
	function automatic row_t predicted_row(int j);
		if (j < FIELD_ROWS) return model_field[FIELD_ROWS - 1 - j];
		return OBSTACLE_ROM[(model_idx + j - FIELD_ROWS) % ROM_DEPTH];
	endfunction

	function automatic int state_index(player_pos_t p);
		return int'(p.p1_col) * 4 + int'(p.p2_col) - int'(P2_MIN_COL);
	endfunction

	function automatic player_pos_t pos_of(int s);
		player_pos_t p;
		p.p1_col = col_t'(s / 4);
		p.p2_col = P2_MIN_COL + col_t'(s % 4);
		return p;
	endfunction

	// One move per step, searched backwards from the winning step
	function automatic int pick_dodge_move();
		int n;
		player_pos_t np;
		n = WIN_SCORE - model_score;
		reach_tbl[n] = '1;
		for (int j = n - 1; j >= 1; j--) begin
			reach_tbl[j] = '0;
			for (int s = 0; s < 16; s++) begin
				for (int m = 0; m < 3; m++) begin
					np = move_players(pos_of(s), m);
					if (lane_clear(predicted_row(j), np) && reach_tbl[j + 1][state_index(np)])
						reach_tbl[j][s] = 1'b1;
				end
			end
		end
		for (int m = 0; m < 3; m++) begin
			np = move_players(model_pos, m);
			if (lane_clear(predicted_row(0), np) && reach_tbl[1][state_index(np)]) return m;
		end
		// No safe path, the checks will show it
		return 0;
	endfunction

	task automatic restart_model(input game_state_t st);
		model_state = st;
		model_score = '0;
		model_alive = 2'b11;
		model_pos.p1_col = P1_START_COL;
		model_pos.p2_col = P2_START_COL;
		model_idx = 0;
		for (int r = 0; r < FIELD_ROWS; r++) model_field[r] = '0;
	endtask

	// One game step, bottom row tested then dropped
	task automatic advance_model();
		hit_t h;
		h.p1 = model_field[FIELD_ROWS - 1][model_pos.p1_col];
		h.p2 = model_field[FIELD_ROWS - 1][model_pos.p2_col];
		for (int r = FIELD_ROWS - 1; r > 0; r--) model_field[r] = model_field[r - 1];
		model_field[0] = OBSTACLE_ROM[model_idx];
		model_idx = (model_idx + 1) % ROM_DEPTH;
		if (h.p1 || h.p2) begin
			model_state = st_result;
			model_alive = ~h;
		end else begin
			model_score = model_score + 8'd1;
			if (model_score == WIN_SCORE) begin
				model_state = st_result;
				model_alive = 2'b11;
			end
		end
	endtask

	// ==============================
	// Check helpers
	// ==============================
	task automatic check_row(input int a, input row_t exp);
		@(posedge clock_50);
		#1;
		disp_addr = row_addr_t'(a);
		@(negedge clock_50);
		check_count++;
		assert (disp_data === exp) else begin
			$display("ERROR disp_data row %0d: got %h, expected %h", a, disp_data, exp);
			error_count++;
		end
	endtask

	task automatic check_frame();
		for (int a = 0; a < 8; a++) check_row(a, expected_row(a));
	endtask

	task automatic check_score(input score_t exp);
		@(negedge clock_50);
		check_count++;
		assert (score === exp) else begin
			$display("ERROR score: got %h, expected %h", score, exp);
			error_count++;
		end
	endtask

	// Step shows as a score change or a new bottom row
	task automatic wait_for_step();
		row_t prow;
		int n;
		bit seen;
		prow = player_bits(model_pos);
		seen = 1'b0;
		n = 0;
		@(posedge clock_50);
		#1;
		disp_addr = PLAYER_ROW;
		while (!seen && n < 2 * STEP_CYCLES) begin
			@(negedge clock_50);
			seen = (score !== model_score) || (disp_data !== prow);
			n++;
		end
		check_count++;
		assert (seen) else begin
			$display("No game step seen within %0d cycles", 2 * STEP_CYCLES);
			error_count++;
		end
	endtask

	`include "game_tests.svh"

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		clock_50     = 1'b0;
		rst_n        = 1'b0;
		start_button = 1'b1;
		left_button  = 1'b1;
		right_button = 1'b1;
		disp_addr    = '0;
		restart_model(st_idle);
		repeat (10) @(posedge clock_50);
		#1;
		rst_n = 1'b1;

		idle_buttons_ignored();
		start_clears_field();
		players_clamp();
		field_follows_table();
		collision_ends_game();
		steered_game_wins();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verilog/game_top.sv ====
/* Top level of the two-player dodging game
   Raw buttons in, frame rows out through the row-address and row-data port */
`timescale 1ns/1ps

module game_top #(
	parameter int step_cycles     = 5000000,
	parameter int debounce_cycles = 500000
) (
	input  logic                clock_50,
	input  logic                rst_n,
	input  logic                start_button,
	input  logic                left_button,
	input  logic                right_button,
	input  game_pkg::row_addr_t disp_addr,
	output game_pkg::row_t      disp_data,
	output game_pkg::score_t    score
);

	import game_pkg::*;

	logic        start_press;
	logic        left_press;
	logic        right_press;
	field_ctrl_t field_ctrl;
	logic        move_en;
	game_state_t state;
	hit_t        alive;
	hit_t        hit;
	player_pos_t pos;
	row_t        rows [FIELD_ROWS];

	// ==============================
	// Buttons
	// ==============================
	button_debounce #(.debounce_cycles(debounce_cycles)) u_start_db (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (start_button),
		.press    (start_press)
	);

	button_debounce #(.debounce_cycles(debounce_cycles)) u_left_db (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (left_button),
		.press    (left_press)
	);

	button_debounce #(.debounce_cycles(debounce_cycles)) u_right_db (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (right_button),
		.press    (right_press)
	);

	// ==============================
	// Control
	// ==============================
	game_fsm #(.step_cycles(step_cycles)) u_game_fsm (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start_press (start_press),
		.left_press  (left_press),
		.right_press (right_press),
		.hit         (hit),
		.field_ctrl  (field_ctrl),
		.move_en     (move_en),
		.state       (state),
		.alive       (alive),
		.score       (score)
	);

	// ==============================
	// Datapath and display
	// ==============================
	player_position u_player_position (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.clear       (field_ctrl.clear),
		.move_en     (move_en),
		.left_press  (left_press),
		.right_press (right_press),
		.pos         (pos)
	);

	obstacle_field u_obstacle_field (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.field_ctrl (field_ctrl),
		.pos        (pos),
		.rows       (rows),
		.hit        (hit)
	);

	frame_composer u_frame_composer (
		.state     (state),
		.alive     (alive),
		.rows      (rows),
		.pos       (pos),
		.disp_addr (disp_addr),
		.disp_data (disp_data)
	);

endmodule

// ==== verilog/frame_composer.sv ====
/* Row readout of the displayed frame
   Combinational from the row address, picks a screen or the live field */
`timescale 1ns/1ps

module frame_composer (
	input  game_pkg::game_state_t state,
	input  game_pkg::hit_t        alive,
	input  game_pkg::row_t        rows [game_pkg::FIELD_ROWS],
	input  game_pkg::player_pos_t pos,
	input  game_pkg::row_addr_t   disp_addr,
	output game_pkg::row_t        disp_data
);

	import game_pkg::*;

	screen_t result_screen;
	row_t    player_row;

	// ==============================
	// Result screen select
	// ==============================
	always_comb begin
		unique case ({alive.p1, alive.p2})
			2'b11:   result_screen = SCREEN_WIN;
			2'b10:   result_screen = SCREEN_P1;
			2'b01:   result_screen = SCREEN_P2;
			default: result_screen = SCREEN_OVER;
		endcase
	end

	// Bottom row lights one column per player
	assign player_row = (row_t'(1) << pos.p1_col) | (row_t'(1) << pos.p2_col);

	// ==============================
	// Row mux
	// ==============================
	always_comb begin
		unique case (state)
			st_idle: begin
				disp_data = SCREEN_START[disp_addr];
			end
			st_result: begin
				disp_data = result_screen[disp_addr];
			end
			st_play: begin
				// Field above, players on the last row
				if (disp_addr == PLAYER_ROW) begin
					disp_data = player_row;
				end else begin
					disp_data = rows[disp_addr];
				end
			end
			default: begin
				disp_data = '0;
			end
		endcase
	end

endmodule

// ==== verilog/obstacle_field.sv ====
/* Falling obstacle rows above the players' row
   Shifts one row per step from the pattern table and flags hits on the bottom row */
`timescale 1ns/1ps

module obstacle_field (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  game_pkg::field_ctrl_t field_ctrl,
	input  game_pkg::player_pos_t pos,
	output game_pkg::row_t        rows [game_pkg::FIELD_ROWS],
	output game_pkg::hit_t        hit
);

	import game_pkg::*;

	// Next pattern table entry to enter at the top
	logic [$clog2(ROM_DEPTH) - 1:0] rom_idx;

	// ==============================
	// Field shift register
	// ==============================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			rom_idx <= '0;
			for (int r = 0; r < FIELD_ROWS; r++) begin
				rows[r] <= '0;
			end
		end else if (field_ctrl.clear) begin
			// Empty field, table from the start
			rom_idx <= '0;
			for (int r = 0; r < FIELD_ROWS; r++) begin
				rows[r] <= '0;
			end
		end else if (field_ctrl.step) begin
			// Bottom row drops out after the hit test
			for (int r = FIELD_ROWS - 1; r > 0; r--) begin
				rows[r] <= rows[r - 1];
			end
			rows[0] <= OBSTACLE_ROM[rom_idx];
			// Index wraps with the table size
			rom_idx <= rom_idx + 1'b1;
		end
	end

	// ==============================
	// Hit detection
	// ==============================
	// Only meaningful in the step cycle
	// Old row 6 lands on the players' row
	assign hit.p1 = field_ctrl.step && rows[FIELD_ROWS - 1][pos.p1_col];
	assign hit.p2 = field_ctrl.step && rows[FIELD_ROWS - 1][pos.p2_col];

endmodule

// ==== verilog/player_position.sv ====
/* Column registers of both players
   Moved together by left and right presses, each clamped to its own half */
`timescale 1ns/1ps

module player_position (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  logic                  clear,
	input  logic                  move_en,
	input  logic                  left_press,
	input  logic                  right_press,
	output game_pkg::player_pos_t pos
);

	import game_pkg::*;

	logic move_left;
	logic move_right;

	// Both buttons in one cycle cancel
	assign move_left  = move_en && left_press && !right_press;
	assign move_right = move_en && right_press && !left_press;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			pos.p1_col <= P1_START_COL;
			pos.p2_col <= P2_START_COL;
		end else if (clear) begin
			pos.p1_col <= P1_START_COL;
			pos.p2_col <= P2_START_COL;
		end else if (move_left) begin
			// Saturate at the left edge of each half
			if (pos.p1_col != P1_MIN_COL) begin
				pos.p1_col <= pos.p1_col - 3'd1;
			end
			if (pos.p2_col != P2_MIN_COL) begin
				pos.p2_col <= pos.p2_col - 3'd1;
			end
		end else if (move_right) begin
			// Saturate at the right edge of each half
			if (pos.p1_col != P1_MAX_COL) begin
				pos.p1_col <= pos.p1_col + 3'd1;
			end
			if (pos.p2_col != P2_MAX_COL) begin
				pos.p2_col <= pos.p2_col + 3'd1;
			end
		end
	end

endmodule

// ==== verilog/game_fsm.sv ====
/* Game control of the dodging game
   Holds the game state, the step timer and the score, and drives the datapath */
`timescale 1ns/1ps

module game_fsm #(
	parameter int step_cycles = 5000000
) (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  logic                  start_press,
	input  logic                  left_press,
	input  logic                  right_press,
	input  game_pkg::hit_t        hit,
	output game_pkg::field_ctrl_t field_ctrl,
	output logic                  move_en,
	output game_pkg::game_state_t state,
	output game_pkg::hit_t        alive,
	output game_pkg::score_t      score
);

	import game_pkg::*;

	// Cycles since the last step
	logic [$clog2(step_cycles) - 1:0] step_timer;
	logic   step_due;
	logic   any_press;
	logic   any_hit;
	score_t score_next;

	// ==============================
	// Datapath controls
	// ==============================
	assign step_due   = (state == st_play) && (step_timer == step_cycles - 1);
	assign any_press  = start_press | left_press | right_press;
	assign any_hit    = hit.p1 | hit.p2;
	assign score_next = score + 8'd1;

	// Clear in the same cycle as the start press
	assign field_ctrl.clear = (state == st_idle) && start_press;
	assign field_ctrl.step  = step_due;
	// Moves only count during play
	assign move_en          = (state == st_play);

	// ==============================
	// Step timer
	// ==============================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			step_timer <= '0;
		end else if (state == st_play) begin
			if (step_due) begin
				step_timer <= '0;
			end else begin
				step_timer <= step_timer + 1'b1;
			end
		end else if (any_press) begin
			// Idle or result screen, any button restarts the phase
			step_timer <= '0;
		end
	end

	// ==============================
	// State, score and alive flags
	// ==============================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			score <= '0;
			alive <= hit_t'(2'b11);
		end else begin
			unique case (state)
				st_idle: begin
					if (start_press) begin
						state <= st_play;
						score <= '0;
						alive <= hit_t'(2'b11);
					end
				end
				st_play: begin
					if (step_due) begin
						if (any_hit) begin
							// Score frozen, survivors shown next
							state <= st_result;
							alive <= hit_t'(~hit);
						end else begin
							score <= score_next;
							// Win on the step that reaches the target
							if (score_next == WIN_SCORE) begin
								state <= st_result;
								alive <= hit_t'(2'b11);
							end
						end
					end
				end
				st_result: begin
					// Score kept on the way back
					if (start_press) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== verilog/button_debounce.sv ====
/* Debounce for one active-low push button
   Emits a single-cycle press pulse once the button has been held long enough */
`timescale 1ns/1ps

module button_debounce #(
	parameter int debounce_cycles = 500000
) (
	input  logic clock_50,
	input  logic rst_n,
	input  logic button_n,
	output logic press
);

	// Two-stage synchronizer
	logic [1:0] sync_ff;
	// Consecutive low cycles, saturates at the threshold
	logic [$clog2(debounce_cycles + 1) - 1:0] low_cnt;
	logic btn_low;

	assign btn_low = ~sync_ff[1];

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			sync_ff <= 2'b11;
			low_cnt <= '0;
			press   <= 1'b0;
		end else begin
			sync_ff <= {sync_ff[0], button_n};
			// Pulse only on the cycle the count first hits the threshold
			press   <= btn_low && (low_cnt == debounce_cycles - 1);
			if (!btn_low) begin
				// Release rearms the filter
				low_cnt <= '0;
			end else if (low_cnt != debounce_cycles) begin
				low_cnt <= low_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/game_pkg.sv ====
/* Types, screens, obstacle table and game constants of the dodging game
   Compiled before all RTL and testbench files, then imported where needed */
package game_pkg;

	// ==============================
	// Widths
	// ==============================
	// One matrix row, bit c lights column c
	typedef logic [7:0] row_t;
	// Row 0 is the top, row 7 the players' row
	typedef logic [2:0] row_addr_t;
	typedef logic [2:0] col_t;
	typedef logic [7:0] score_t;

	typedef struct packed {
		col_t p1_col;
		col_t p2_col;
	} player_pos_t;

	// Hit flags or alive flags
	typedef struct packed {
		logic p1;
		logic p2;
	} hit_t;

	typedef struct packed {
		logic clear;
		logic step;
	} field_ctrl_t;

	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_play   = 2'd1,
		st_result = 2'd2
	} game_state_t;

	// ==============================
	// Game constants
	// ==============================
	localparam int        FIELD_ROWS   = 7;
	localparam row_addr_t PLAYER_ROW   = 3'd7;
	localparam col_t      P1_MIN_COL   = 3'd0;
	localparam col_t      P1_MAX_COL   = 3'd3;
	localparam col_t      P2_MIN_COL   = 3'd4;
	localparam col_t      P2_MAX_COL   = 3'd7;
	localparam col_t      P1_START_COL = 3'd1;
	localparam col_t      P2_START_COL = 3'd6;
	localparam score_t    WIN_SCORE    = 8'd24;
	localparam int        ROM_DEPTH    = 8;

	// Obstacle rows, used in a cycle
	// Every entry leaves a free column in each half
	localparam row_t OBSTACLE_ROM [ROM_DEPTH] = '{
		8'b1000_1001, 8'b0100_0010, 8'b0011_1001, 8'b1000_0100,
		8'b0110_0010, 8'b0001_1001, 8'b0100_0100, 8'b1010_1010
	};

	// ==============================
	// Screens, row 0 first
	// ==============================
	typedef row_t screen_t [0:7];

	localparam screen_t SCREEN_START = '{
		8'b00000000, 8'b01100110, 8'b01000100, 8'b01000100,
		8'b00100010, 8'b00100010, 8'b01100110, 8'b00000000
	};
	// Both players hit
	localparam screen_t SCREEN_OVER = '{
		8'b00000000, 8'b01100110, 8'b10001001, 8'b10001001,
		8'b10111001, 8'b10011001, 8'b01100110, 8'b00000000
	};
	// Player 1 alive, player 2 hit
	localparam screen_t SCREEN_P1 = '{
		8'b00001111, 8'b01101111, 8'b00001111, 8'b10011111,
		8'b01101111, 8'b00001111, 8'b00001111, 8'b00001111
	};
	// Player 2 alive, player 1 hit
	localparam screen_t SCREEN_P2 = '{
		8'b11110000, 8'b11110110, 8'b11110000, 8'b11111001,
		8'b11110110, 8'b11110000, 8'b11110000, 8'b11110000
	};
	localparam screen_t SCREEN_WIN = '{
		8'b00000000, 8'b00100100, 8'b00100100, 8'b00000000,
		8'b01000010, 8'b00100100, 8'b00111100, 8'b00000000
	};

endpackage
